/* all.f */
rtl/eeprom_pkg.sv
rtl/i2c_bus_master.sv
rtl/eeprom_device.sv
rtl/eeprom_subsys.sv
tests/eeprom_asserts.sv
tests/eeprom_checker.sv
tests/tb_top.sv

/* rtl/eeprom_device.sv */
`timescale 1ns/10ps

module eeprom_device (
    input  logic scl,
    input  logic reset,
    input  logic bus_clk,
    input  logic sda_in,
    output logic sda_out
);

    typedef enum logic [2:0] {
        IDLE,
        CTRL,
        ADDR,
        WDATA,
        RDATA
    } state_t;

    state_t                        state;
    logic                          clk_s;
    logic                          clk_p;
    logic                          sda_s;
    logic                          sda_p;
    logic                          clk_rise;
    logic                          clk_fall;
    logic                          start_det;
    logic                          stop_det;
    logic [3:0]                    bit_cnt;
    logic                          ack_phase;
    logic [7:0]                    shift;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [7:0]                    rd_byte;
    logic                          byte_done;
    logic                          dev_match;
    logic                          mem_we;

    logic [7:0] mem [2**eeprom_pkg::ADDR_W];

    // current and previous bus samples
    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            clk_s <= 1'b1;
            clk_p <= 1'b1;
            sda_s <= 1'b1;
            sda_p <= 1'b1;
        end
        else
        begin
            clk_s <= bus_clk;
            clk_p <= clk_s;
            sda_s <= sda_in;
            sda_p <= sda_s;
        end
    end

    assign clk_rise  = clk_s & ~clk_p;
    assign clk_fall  = ~clk_s & clk_p;
    assign start_det = clk_s & clk_p & sda_p & ~sda_s;
    assign stop_det  = clk_s & clk_p & ~sda_p & sda_s;

    // eight bits in, now at the acknowledge slot
    assign byte_done = clk_fall && !ack_phase && (bit_cnt == 4'd8);
    assign dev_match = (shift[7:4] == eeprom_pkg::DEV_CODE);
    assign mem_we    = byte_done && (state == WDATA);
    assign rd_byte   = mem[addr];

    always_ff @(posedge scl)
    begin
        if (mem_we)
            mem[addr] <= shift;
    end

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            state     <= IDLE;
            bit_cnt   <= '0;
            ack_phase <= 1'b0;
            sda_out   <= 1'b1;
        end
        else if (start_det)
        begin
            state     <= CTRL;
            bit_cnt   <= '0;
            ack_phase <= 1'b0;
            sda_out   <= 1'b1;
        end
        else if (stop_det)
        begin
            state     <= IDLE;
            bit_cnt   <= '0;
            ack_phase <= 1'b0;
            sda_out   <= 1'b1;
        end
        else
        begin
            if (clk_rise && state != IDLE && bit_cnt != 4'd8)
            begin
                shift   <= {shift[6:0], sda_s};
                bit_cnt <= bit_cnt + 4'd1;
            end

            if (clk_fall && ack_phase)
            begin
                // end of acknowledge, release or start sending
                ack_phase <= 1'b0;
                bit_cnt   <= '0;
                if (state == RDATA)
                begin
                    shift   <= rd_byte;
                    sda_out <= rd_byte[7];
                end
                else
                    sda_out <= 1'b1;
            end
            else if (clk_fall && state == RDATA)
            begin
                if (bit_cnt == 4'd8)
                begin
                    // master answers with its not-acknowledge
                    sda_out <= 1'b1;
                    state   <= IDLE;
                end
                else
                    sda_out <= shift[7];
            end
            else if (byte_done)
            begin
                case (state)
                    CTRL:
                    begin
                        if (dev_match)
                        begin
                            sda_out    <= 1'b0;
                            ack_phase  <= 1'b1;
                            addr[10:8] <= shift[3:1];
                            state      <= shift[0] ? RDATA : ADDR;
                        end
                        else
                            state <= IDLE;
                    end
                    ADDR:
                    begin
                        sda_out   <= 1'b0;
                        ack_phase <= 1'b1;
                        addr[7:0] <= shift;
                        state     <= WDATA;
                    end
                    WDATA:
                    begin
                        // byte stored this cycle, wait for stop
                        sda_out   <= 1'b0;
                        ack_phase <= 1'b1;
                        state     <= IDLE;
                    end
                    default:
                    begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

    // device type identifier for 24C16 style parts
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // scl cycles per quarter of a bus bit
    localparam int QUARTER = 4;
    localparam int QTR_W = $clog2(QUARTER);
    localparam logic [QTR_W-1:0] QTR_LAST = QTR_W'(QUARTER - 1);

    // block number plus word address
    localparam int ADDR_W = 11;

    // one bus transaction as issued by the host side
    typedef struct packed {
        // 1 = random read, 0 = byte write
        logic       op;
        logic [3:0] dev_code;
        logic [2:0] block;
        logic [7:0] word_addr;
        logic [7:0] wr_data;
    } cmd_t;

    // returned with done
    typedef struct packed {
        logic [7:0] rd_data;
        logic       ack_error;
    } result_t;

endpackage

/* rtl/eeprom_subsys.sv */
`timescale 1ns/10ps

module eeprom_subsys (
    input  logic                scl,
    input  logic                reset,
    input  logic                cmd_valid,
    input  eeprom_pkg::cmd_t    cmd,
    output logic                busy,
    output logic                done,
    output eeprom_pkg::result_t result
);

    logic bus_clk;
    logic master_sda;
    logic device_sda;
    logic sda;

    // open drain bus, either side pulls low
    assign sda = master_sda & device_sda;

    i2c_bus_master u_master (
        .scl       (scl),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .sda_in    (sda),
        .bus_clk   (bus_clk),
        .sda_out   (master_sda),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    eeprom_device u_device (
        .scl     (scl),
        .reset   (reset),
        .bus_clk (bus_clk),
        .sda_in  (sda),
        .sda_out (device_sda)
    );

endmodule

/* rtl/i2c_bus_master.sv */
`timescale 1ns/10ps

module i2c_bus_master (
    input  logic                scl,
    input  logic                reset,
    input  logic                cmd_valid,
    input  eeprom_pkg::cmd_t    cmd,
    input  logic                sda_in,
    output logic                bus_clk,
    output logic                sda_out,
    output logic                busy,
    output logic                done,
    output eeprom_pkg::result_t result
);

    typedef enum logic [2:0] {
        IDLE,
        START,
        SEND,
        RECV,
        STOP
    } state_t;

    state_t                       state;
    eeprom_pkg::cmd_t             cmd_q;
    logic [eeprom_pkg::QTR_W-1:0] qcnt;
    logic [1:0]                   quarter;
    logic [3:0]                   bit_cnt;
    logic [1:0]                   byte_idx;
    logic [7:0]                   shift;
    logic                         ack_bit;
    logic                         ack_error;
    logic                         tick;
    logic                         last_bit;

    assign tick = (qcnt == eeprom_pkg::QTR_LAST);
    // ninth bit of a byte is the acknowledge slot
    assign last_bit = (bit_cnt == 4'd8);

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            state     <= IDLE;
            qcnt      <= '0;
            quarter   <= '0;
            bit_cnt   <= '0;
            byte_idx  <= '0;
            bus_clk   <= 1'b1;
            sda_out   <= 1'b1;
            busy      <= 1'b0;
            done      <= 1'b0;
            ack_error <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == IDLE)
            begin
                if (cmd_valid)
                begin
                    cmd_q     <= cmd;
                    state     <= START;
                    busy      <= 1'b1;
                    bus_clk   <= 1'b0;
                    byte_idx  <= '0;
                    ack_error <= 1'b0;
                end
            end
            else
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    quarter <= quarter + 2'd1;
                    case (quarter)
                        // clock low, set up the data line
                        2'd0:
                        begin
                            case (state)
                                SEND:    sda_out <= last_bit ? 1'b1 : shift[7];
                                STOP:    sda_out <= 1'b0;
                                default: sda_out <= 1'b1;
                            endcase
                        end
                        2'd1:
                        begin
                            bus_clk <= 1'b1;
                        end
                        // middle of the high phase
                        2'd2:
                        begin
                            if (state == START)
                                sda_out <= 1'b0;
                            else if (state == STOP)
                                sda_out <= 1'b1;
                            else if (!last_bit)
                                shift <= {shift[6:0], sda_in};
                            else
                                ack_bit <= sda_in;
                        end
                        default:
                        begin
                            bus_clk <= 1'b0;
                            case (state)
                                START:
                                begin
                                    state   <= SEND;
                                    bit_cnt <= '0;
                                    shift   <= {cmd_q.dev_code, cmd_q.block, byte_idx != 2'd0};
                                end
                                SEND:
                                begin
                                    if (!last_bit)
                                        bit_cnt <= bit_cnt + 4'd1;
                                    else
                                    begin
                                        bit_cnt <= '0;
                                        if (ack_bit)
                                        begin
                                            // no acknowledge, abort with a stop
                                            ack_error <= 1'b1;
                                            state     <= STOP;
                                        end
                                        else if (byte_idx == 2'd0)
                                        begin
                                            byte_idx <= 2'd1;
                                            shift    <= cmd_q.word_addr;
                                        end
                                        else if (byte_idx == 2'd1)
                                        begin
                                            byte_idx <= 2'd2;
                                            if (cmd_q.op)
                                                state <= START;
                                            else
                                                shift <= cmd_q.wr_data;
                                        end
                                        else
                                            state <= cmd_q.op ? RECV : STOP;
                                    end
                                end
                                RECV:
                                begin
                                    if (!last_bit)
                                        bit_cnt <= bit_cnt + 4'd1;
                                    else
                                    begin
                                        bit_cnt <= '0;
                                        state   <= STOP;
                                    end
                                end
                                default:
                                begin
                                    // stop complete, bus left idle
                                    bus_clk          <= 1'b1;
                                    state            <= IDLE;
                                    busy             <= 1'b0;
                                    done             <= 1'b1;
                                    result.ack_error <= ack_error;
                                    result.rd_data   <= (cmd_q.op && !ack_error) ? shift : '0;
                                end
                            endcase
                        end
                    endcase
                end
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f all.f -o tb_top_sim
then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* tests/eeprom_asserts.sv */
`timescale 1ns/10ps

module eeprom_asserts (
    input logic scl,
    input logic reset,
    input logic bus_clk,
    input logic sda_out,
    input logic framing,
    input logic cmd_valid,
    input logic busy,
    input logic done
);

    // data moves only while the bus clock is low, start and stop excepted
    sda_stable: assert property (@(posedge scl) disable iff (reset)
        (bus_clk && $past(bus_clk) && $changed(sda_out)) |-> $past(framing))
        else $error("master sda changed while bus clock high outside start or stop");

    idle_after_reset: assert property (@(posedge scl) reset |=> (!busy && !done))
        else $error("busy or done high right after reset");

    accept_sets_busy: assert property (@(posedge scl) disable iff (reset)
        (cmd_valid && !busy) |=> busy)
        else $error("busy did not rise after an accepted command");

    done_one_cycle: assert property (@(posedge scl) disable iff (reset) done |=> !done)
        else $error("done held high for more than one cycle");

endmodule

/* tests/eeprom_checker.sv */
`timescale 1ns/10ps

module eeprom_checker (
    input  logic                scl,
    input  logic                reset,
    input  logic                cmd_valid,
    input  eeprom_pkg::cmd_t    cmd,
    input  logic                busy,
    input  logic                done,
    input  eeprom_pkg::result_t result,
    output int                  cmd_count,
    output int                  done_count,
    output int                  errors
);

    // longest command is 40 bus bits of 4 quarters, allow twice that
    localparam int MAX_LATENCY = 2 * 40 * 4 * eeprom_pkg::QUARTER;

    logic [7:0]       model [2**eeprom_pkg::ADDR_W];
    logic             valid [2**eeprom_pkg::ADDR_W];
    eeprom_pkg::cmd_t pend;
    logic             pending;
    int               age;

    task automatic check_result();
        logic [eeprom_pkg::ADDR_W-1:0] a;
        logic                          ack_exp;
        a = {pend.block, pend.word_addr};
        ack_exp = (pend.dev_code != eeprom_pkg::DEV_CODE);
        if (result.ack_error != ack_exp)
        begin
            errors++;
            $display("ERR %0t: command %0d ack_error %0b, expected %0b",
                     $time, cmd_count, result.ack_error, ack_exp);
        end
        else if (ack_exp && result.rd_data != 8'h00)
        begin
            errors++;
            $display("ERR %0t: rejected command %0d returned data %02h, expected 00",
                     $time, cmd_count, result.rd_data);
        end
        else if (!ack_exp && pend.op && valid[a] && result.rd_data != model[a])
        begin
            errors++;
            $display("ERR %0t: read of address %03h returned %02h, expected %02h",
                     $time, a, result.rd_data, model[a]);
        end
        // memory changes only on an accepted write
        if (!ack_exp && !pend.op)
        begin
            model[a] = pend.wr_data;
            valid[a] = 1'b1;
        end
    endtask

    always @(posedge scl)
    begin
        if (reset)
        begin
            pending    = 1'b0;
            age        = 0;
            cmd_count  = 0;
            done_count = 0;
            errors     = 0;
            for (int i = 0; i < 2**eeprom_pkg::ADDR_W; i++)
                valid[i] = 1'b0;
        end
        else
        begin
            if (done)
            begin
                done_count++;
                if (!pending)
                begin
                    errors++;
                    $display("handshake failure at %0t: done pulse with no command", $time);
                end
                else
                    check_result();
                if (busy)
                begin
                    errors++;
                    $display("handshake failure at %0t: busy still high during done", $time);
                end
                pending = 1'b0;
            end
            else if (pending)
            begin
                age++;
                if (!busy)
                begin
                    errors++;
                    pending = 1'b0;
                    $display("handshake failure at %0t: busy fell before done for command %0d",
                             $time, cmd_count);
                end
                else if (age > MAX_LATENCY)
                begin
                    errors++;
                    pending = 1'b0;
                    $display("no done pulse within %0d cycles for command %0d",
                             MAX_LATENCY, cmd_count);
                end
            end
            if (cmd_valid && !busy)
            begin
                pend    = cmd;
                pending = 1'b1;
                age     = 0;
                cmd_count++;
            end
        end
    end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

    localparam int N_BASIC  = 40;
    localparam int N_ROUNDS = 3;
    localparam int N_OVER   = 10;
    localparam int N_BAD    = 20;
    localparam int N_CMDS   = 2 * N_BASIC + N_ROUNDS * 16 + N_OVER * 3 + N_BAD * 2;
    // longest command 40 bits, 4 quarters each, 4 ns scl, doubled
    localparam longint LIMIT_NS = longint'(N_CMDS) * 40 * 4 * eeprom_pkg::QUARTER * 4 * 2;

    logic                scl;
    logic                reset;
    logic                cmd_valid;
    eeprom_pkg::cmd_t    cmd;
    logic                busy;
    logic                done;
    eeprom_pkg::result_t result;
    int                  cmd_count;
    int                  done_count;
    int                  errors;
    logic [10:0]         written [$];

    eeprom_subsys DUT (
        .scl       (scl),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    eeprom_checker u_checker (
        .scl        (scl),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .cmd_count  (cmd_count),
        .done_count (done_count),
        .errors     (errors)
    );

    bind i2c_bus_master eeprom_asserts u_asserts (
        .scl       (scl),
        .reset     (reset),
        .bus_clk   (bus_clk),
        .sda_out   (sda_out),
        .framing   (state == START || state == STOP),
        .cmd_valid (cmd_valid),
        .busy      (busy),
        .done      (done)
    );

    initial
    begin
        scl = 1'b0;
        forever #2 scl = ~scl;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("watchdog expired after %0d ns with commands still running", LIMIT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic eeprom_pkg::cmd_t make_cmd(input logic op, input logic [3:0] code,
                                                  input logic [10:0] a, input logic [7:0] data);
        eeprom_pkg::cmd_t c;
        c.op        = op;
        c.dev_code  = code;
        c.block     = a[10:8];
        c.word_addr = a[7:0];
        c.wr_data   = data;
        return c;
    endfunction

    task automatic send_cmd(input eeprom_pkg::cmd_t c);
        @(negedge scl);
        while (busy)
            @(negedge scl);
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge scl);
        cmd_valid = 1'b0;
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] data);
        send_cmd(make_cmd(1'b0, eeprom_pkg::DEV_CODE, a, data));
        written.push_back(a);
    endtask

    task automatic read_byte(input logic [10:0] a);
        send_cmd(make_cmd(1'b1, eeprom_pkg::DEV_CODE, a, 8'h00));
    endtask

    task automatic end_test(input string name, input int c0, input int e0);
        @(negedge scl);
        while (busy)
            @(negedge scl);
        // one more edge so the checker has seen the last done
        @(negedge scl);
        $display("test %s: %0d commands, %0d errors", name, cmd_count - c0, errors - e0);
    endtask

    initial
    begin
        int unsigned seed_ret;
        logic [10:0] a;
        logic [7:0]  w;
        logic [3:0]  code;
        logic        fail;
        int          c0;
        int          e0;
        seed_ret  = $urandom(32'hefbf4ee0);
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (5) @(posedge scl);
        @(negedge scl);
        reset = 1'b0;

        c0 = cmd_count;
        e0 = errors;
        repeat (N_BASIC)
            write_byte(11'($urandom), 8'($urandom));
        repeat (N_BASIC)
            read_byte(written[$urandom_range(written.size() - 1)]);
        end_test("write_readback", c0, e0);

        // low data bits carry the block number to keep every block distinct
        c0 = cmd_count;
        e0 = errors;
        repeat (N_ROUNDS)
        begin
            w = 8'($urandom);
            for (int b = 0; b < 8; b++)
                write_byte({3'(b), w}, {5'($urandom), 3'(b)});
            for (int b = 0; b < 8; b++)
                read_byte({3'(b), w});
        end
        end_test("block_bits", c0, e0);

        c0 = cmd_count;
        e0 = errors;
        repeat (N_OVER)
        begin
            a = written[$urandom_range(written.size() - 1)];
            write_byte(a, 8'($urandom));
            write_byte(a, 8'($urandom));
            read_byte(a);
        end
        end_test("overwrite", c0, e0);

        c0 = cmd_count;
        e0 = errors;
        repeat (N_BAD)
        begin
            do
                code = 4'($urandom);
            while (code == eeprom_pkg::DEV_CODE);
            // aim at stored data so a wrongly accepted write shows up on the read
            a = written[$urandom_range(written.size() - 1)];
            send_cmd(make_cmd(1'($urandom), code, a, 8'($urandom)));
            read_byte(a);
        end
        end_test("wrong_device_code", c0, e0);

        fail = (errors != 0);
        if (done_count != cmd_count)
        begin
            $display("missing done pulse: %0d commands accepted but %0d done pulses seen",
                     cmd_count, done_count);
            fail = 1'b1;
        end
        $display("summary: %0d commands, %0d done pulses, %0d errors",
                 cmd_count, done_count, errors);
        if (fail)
            $display("Simulation finished: FAIL");
        else
            $display("Simulation finished: PASS");
        $finish;
    end

endmodule
